// ==== hw/soc_cfg.svh ====
////////////////////
// Widths, address map and device ids of the bus core.
// Bases and map sizes must stay word aligned; the map must not overlap.
////////////////////
`ifndef SOC_CFG_SVH
`define SOC_CFG_SVH

// Bus data width and byte selects
`define ARCHBITSZ 32
`define SELBITSZ 4

// Scratch RAM, 256 words
`define SCRATCH_BASE 32'h0000
`define SCRATCH_MAPSZ 32'h0400
`define SCRATCH_ID 16'd1
`define SCRATCH_USEINTR 1'b0

// Device table, 64 words
`define DEVTBL_BASE 32'h0400
`define DEVTBL_MAPSZ 32'h0100
`define DEVTBL_ID 16'd7
`define DEVTBL_USEINTR 1'b0

// Device-table word holding the two reset bits
`define CTRL_WORD 6'd63

// Word offset width on the stage link, sized for the largest slave
`define OFFSET_BITSZ 8

// Reset counter reloads to all ones
`define RST_CNTR_BITSZ 4

`endif

// ==== hw/soc_pkg.sv ====
////////////////////
// Bus operation and slave index encodings.
////////////////////
`default_nettype none

package soc_pkg;

	// Bus operation, same encoding as the peripheral bus
	typedef enum logic [1:0] {
		OP_NOP  = 2'b00,
		OP_WR   = 2'b01,
		OP_RD   = 2'b10,
		// Swap: old value comes back, new value is stored
		OP_RDWR = 2'b11
	} pi1_op_t;

	// Slave selected by the address map.
	// Order matches the device-table entries
	typedef enum logic [1:0] {
		SLV_SCRATCH = 2'd0,
		SLV_DEVTBL  = 2'd1,
		SLV_INVALID = 2'd2
	} slave_idx_t;

endpackage

`default_nettype wire

// ==== hw/pi1_stage_if.sv ====
////////////////////
// One decoded access between the stages.
// Four-phase req/ack, fields held while req is high.
////////////////////
`default_nettype none

`include "soc_cfg.svh"

interface pi1_stage_if import soc_pkg::*; ();

	// Decode stage side
	logic                      req;
	pi1_op_t                   op;
	slave_idx_t                slave;
	logic [`OFFSET_BITSZ-1:0]  offset;
	logic [`ARCHBITSZ-1:0]     wdata;
	logic [`SELBITSZ-1:0]      sel;

	// Device stage side, rdata valid with ack
	logic                      ack;
	logic [`ARCHBITSZ-1:0]     rdata;

	modport up (
		output req, op, slave, offset, wdata, sel,
		input  ack, rdata
	);

	modport down (
		input  req, op, slave, offset, wdata, sel,
		output ack, rdata
	);

endinterface

`default_nettype wire

// ==== hw/rst_seq.sv ====
////////////////////
// Reset counter and software reset decode.
// Power-off holds the system in reset until rst_p.
////////////////////
`default_nettype none

`include "soc_cfg.svh"

module rst_seq (
	input  wire  clk24mhz,
	input  wire  rst_p,
	input  wire  rst0_i,
	input  wire  rst1_i,
	output logic sys_rst_o,
	output logic pwr_off_o
);

	logic [`RST_CNTR_BITSZ-1:0] rst_cntr;
	logic                       sw_cold_rst;
	logic                       sw_warm_rst;
	logic                       sw_pwr_off;
	logic                       reload;

	// Decode of the device-table reset bits
	assign sw_warm_rst = ~rst0_i & rst1_i;
	assign sw_cold_rst = rst0_i & rst1_i;
	assign sw_pwr_off  = rst0_i & ~rst1_i;

	// No global set/reset here, so cold reset takes the warm path
	assign reload = rst_p | sw_warm_rst | sw_cold_rst;

	always_ff @(posedge clk24mhz) begin
		if (reload) begin
			rst_cntr <= '1;
		end else if (rst_cntr != '0) begin
			rst_cntr <= rst_cntr - 1'b1;
		end
	end

	// Latched until the board reset comes
	always_ff @(posedge clk24mhz) begin
		if (rst_p) begin
			pwr_off_o <= 1'b0;
		end else if (sw_pwr_off) begin
			pwr_off_o <= 1'b1;
		end
	end

	// Released at the edge where the count reaches zero
	assign sys_rst_o = pwr_off_o | (rst_cntr != '0);

endmodule

`default_nettype wire

// ==== hw/dev_table.sv ====
////////////////////
// Read-only device table plus the reset control word.
// Two words per slave in map order; unknown words read zero.
////////////////////
`default_nettype none

`include "soc_cfg.svh"

module dev_table import soc_pkg::*; (
	input  wire                    clk24mhz,
	input  wire                    sys_rst_i,
	input  wire                    wr_i,
	input  wire [5:0]              offset_i,
	input  wire [`ARCHBITSZ-1:0]   wdata_i,
	output logic [`ARCHBITSZ-1:0]  rdata_o,
	output logic                   rst0_o,
	output logic                   rst1_o
);

	logic [4:0]            entry;
	logic [`ARCHBITSZ-1:0] id_word;
	logic [`ARCHBITSZ-1:0] mapsz_word;

	assign entry = offset_i[5:1];

	// useintr in bit 31, id in 15:0
	always_comb begin
		id_word    = '0;
		mapsz_word = '0;
		case (entry)
			5'(SLV_SCRATCH): begin
				id_word    = {`SCRATCH_USEINTR, 15'd0, `SCRATCH_ID};
				mapsz_word = `SCRATCH_MAPSZ;
			end
			5'(SLV_DEVTBL): begin
				id_word    = {`DEVTBL_USEINTR, 15'd0, `DEVTBL_ID};
				mapsz_word = `DEVTBL_MAPSZ;
			end
			// Invalid device and unused entries stay zero
			default: ;
		endcase
	end

	always_comb begin
		if (offset_i == `CTRL_WORD)
			rdata_o = {30'd0, rst1_o, rst0_o};
		else
			rdata_o = offset_i[0] ? mapsz_word : id_word;
	end

	always_ff @(posedge clk24mhz) begin
		if (sys_rst_i) begin
			rst0_o <= 1'b0;
			rst1_o <= 1'b0;
		end else if (wr_i && offset_i == `CTRL_WORD) begin
			rst0_o <= wdata_i[0];
			rst1_o <= wdata_i[1];
		end
	end

endmodule

`default_nettype wire

// ==== hw/dev_stage.sv ====
////////////////////
// Runs one access on scratch RAM, device table or invalid device.
// RAM contents survive sys_rst.
////////////////////
`default_nettype none

`include "soc_cfg.svh"

module dev_stage import soc_pkg::*; (
	input  wire        clk24mhz,
	input  wire        sys_rst_i,
	pi1_stage_if.down  stage,
	output logic       rst0_o,
	output logic       rst1_o
);

	localparam int RAM_WORDS = `SCRATCH_MAPSZ / (`ARCHBITSZ / 8);

	logic [`ARCHBITSZ-1:0] ram [RAM_WORDS];
	logic                  start;
	logic                  is_wr;
	logic                  is_rd;
	logic                  ram_wr;
	logic                  tbl_wr;
	logic [`ARCHBITSZ-1:0] tbl_rdata;
	logic [`ARCHBITSZ-1:0] rd_word;

	// High for the single cycle before ack rises
	assign start  = stage.req & ~stage.ack;
	assign is_wr  = (stage.op == OP_WR) | (stage.op == OP_RDWR);
	assign is_rd  = (stage.op == OP_RD) | (stage.op == OP_RDWR);
	assign ram_wr = start & is_wr & (stage.slave == SLV_SCRATCH);
	assign tbl_wr = start & is_wr & (stage.slave == SLV_DEVTBL);

	dev_table u_dev_table (
		.clk24mhz  (clk24mhz),
		.sys_rst_i (sys_rst_i),
		.wr_i      (tbl_wr),
		.offset_i  (stage.offset[5:0]),
		.wdata_i   (stage.wdata),
		.rdata_o   (tbl_rdata),
		.rst0_o    (rst0_o),
		.rst1_o    (rst1_o)
	);

	// Invalid device reads zero
	always_comb begin
		case (stage.slave)
			SLV_SCRATCH: rd_word = ram[stage.offset];
			SLV_DEVTBL:  rd_word = tbl_rdata;
			default:     rd_word = '0;
		endcase
	end

	always_ff @(posedge clk24mhz) begin
		if (sys_rst_i) begin
			stage.ack <= 1'b0;
		end else if (start) begin
			stage.ack <= 1'b1;
		end else if (!stage.req) begin
			stage.ack <= 1'b0;
		end
	end

	// Old word is taken before the write lands, which gives the swap
	always_ff @(posedge clk24mhz) begin
		if (start)
			stage.rdata <= is_rd ? rd_word : '0;
	end

	// Byte-lane merge
	always_ff @(posedge clk24mhz) begin
		if (ram_wr) begin
			for (int b = 0; b < `SELBITSZ; b++) begin
				if (stage.sel[b])
					ram[stage.offset][b*8 +: 8] <= stage.wdata[b*8 +: 8];
			end
		end
	end

endmodule

`default_nettype wire

// ==== hw/addr_decode.sv ====
////////////////////
// Address map and top-level handshake. One access in flight.
// Unmapped addresses go to the invalid device.
////////////////////
`default_nettype none

`include "soc_cfg.svh"

module addr_decode import soc_pkg::*; (
	input  wire                    clk24mhz,
	input  wire                    sys_rst_i,
	input  wire                    req_i,
	input  wire pi1_op_t           op_i,
	input  wire [`ARCHBITSZ-1:0]   addr_i,
	input  wire [`ARCHBITSZ-1:0]   wdata_i,
	input  wire [`SELBITSZ-1:0]    sel_i,
	output logic                   ack_o,
	output logic [`ARCHBITSZ-1:0]  rdata_o,
	pi1_stage_if.up                stage
);

	localparam logic [2:0] ST_IDLE    = 3'd0;
	localparam logic [2:0] ST_LAUNCH  = 3'd1;
	localparam logic [2:0] ST_WAIT    = 3'd2;
	localparam logic [2:0] ST_ACK     = 3'd3;
	localparam logic [2:0] ST_RELEASE = 3'd4;

	logic [2:0]               state;
	logic [`ARCHBITSZ-1:0]    addr_aligned;
	logic [`ARCHBITSZ-1:0]    scratch_rel;
	logic [`ARCHBITSZ-1:0]    devtbl_rel;
	slave_idx_t               slave_d;
	logic [`OFFSET_BITSZ-1:0] offset_d;

	assign addr_aligned = {addr_i[`ARCHBITSZ-1:2], 2'b00};
	// Unsigned wrap makes one compare cover both ends of a region
	assign scratch_rel  = addr_aligned - `SCRATCH_BASE;
	assign devtbl_rel   = addr_aligned - `DEVTBL_BASE;

	always_comb begin
		if (scratch_rel < `SCRATCH_MAPSZ) begin
			slave_d  = SLV_SCRATCH;
			offset_d = scratch_rel[`OFFSET_BITSZ+1:2];
		end else if (devtbl_rel < `DEVTBL_MAPSZ) begin
			slave_d  = SLV_DEVTBL;
			offset_d = devtbl_rel[`OFFSET_BITSZ+1:2];
		end else begin
			slave_d  = SLV_INVALID;
			offset_d = '0;
		end
	end

	always_ff @(posedge clk24mhz) begin
		if (sys_rst_i) begin
			state     <= ST_IDLE;
			stage.req <= 1'b0;
			ack_o     <= 1'b0;
		end else begin
			case (state)
				ST_IDLE:    if (req_i) state <= ST_LAUNCH;
				ST_LAUNCH: begin
					stage.req <= 1'b1;
					state     <= ST_WAIT;
				end
				ST_WAIT: if (stage.ack) begin
					ack_o <= 1'b1;
					state <= ST_ACK;
				end
				// Master release ripples down to the device stage
				ST_ACK: if (!req_i) begin
					stage.req <= 1'b0;
					state     <= ST_RELEASE;
				end
				ST_RELEASE: if (!stage.ack) begin
					ack_o <= 1'b0;
					state <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Fields captured once per access, read data held until the next one
	always_ff @(posedge clk24mhz) begin
		if (state == ST_IDLE && req_i) begin
			stage.op     <= op_i;
			stage.slave  <= slave_d;
			stage.offset <= offset_d;
			stage.wdata  <= wdata_i;
			stage.sel    <= sel_i;
		end
		if (state == ST_WAIT && stage.ack)
			rdata_o <= stage.rdata;
	end

endmodule

`default_nettype wire

// ==== hw/soc_top.sv ====
////////////////////
// Bus core top level. Four-phase req/ack on the ports.
// Hold fields stable while req_i is high.
////////////////////
`default_nettype none

`include "soc_cfg.svh"

module soc_top (
	input  wire                    clk24mhz,
	input  wire                    rst_p,
	input  wire                    req_i,
	input  wire soc_pkg::pi1_op_t  op_i,
	input  wire [`ARCHBITSZ-1:0]   addr_i,
	input  wire [`ARCHBITSZ-1:0]   wdata_i,
	input  wire [`SELBITSZ-1:0]    sel_i,
	output logic                   ack_o,
	output logic [`ARCHBITSZ-1:0]  rdata_o,
	output logic                   sys_rst_o,
	output logic                   pwr_off_o
);

	logic rst0;
	logic rst1;

	pi1_stage_if stage_if ();

	rst_seq u_rst_seq (
		.clk24mhz  (clk24mhz),
		.rst_p     (rst_p),
		.rst0_i    (rst0),
		.rst1_i    (rst1),
		.sys_rst_o (sys_rst_o),
		.pwr_off_o (pwr_off_o)
	);

	addr_decode u_addr_decode (
		.clk24mhz  (clk24mhz),
		.sys_rst_i (sys_rst_o),
		.req_i     (req_i),
		.op_i      (op_i),
		.addr_i    (addr_i),
		.wdata_i   (wdata_i),
		.sel_i     (sel_i),
		.ack_o     (ack_o),
		.rdata_o   (rdata_o),
		.stage     (stage_if.up)
	);

	// Reset bits come back from the device table
	dev_stage u_dev_stage (
		.clk24mhz  (clk24mhz),
		.sys_rst_i (sys_rst_o),
		.stage     (stage_if.down),
		.rst0_o    (rst0),
		.rst1_o    (rst1)
	);

endmodule

`default_nettype wire

// ==== testbench/tb_soc.sv ====
////////////////////
// Bus master for soc_top, driven by testbench/soc_patterns.txt.
// Run from the project root so that the pattern path resolves.
////////////////////
`default_nettype none

`include "soc_cfg.svh"

module tb_soc import soc_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	logic                  clk24mhz = 1'b0;
	logic                  rst_p;
	logic                  req_i;
	pi1_op_t               op_i;
	logic [`ARCHBITSZ-1:0] addr_i;
	logic [`ARCHBITSZ-1:0] wdata_i;
	logic [`SELBITSZ-1:0]  sel_i;
	logic                  ack_o;
	logic [`ARCHBITSZ-1:0] rdata_o;
	logic                  sys_rst_o;
	logic                  pwr_off_o;

	// One entry per pattern line
	logic [7:0]  pat_cmd[$];
	logic [1:0]  pat_op[$];
	logic [31:0] pat_addr[$];
	logic [31:0] pat_wdata[$];
	logic [3:0]  pat_sel[$];
	logic [31:0] pat_exp[$];

	int check_fails     = 0;
	int watchdog_cycles = 0;
	bit patterns_loaded = 1'b0;

	soc_top UUT (
		.clk24mhz  (clk24mhz),
		.rst_p     (rst_p),
		.req_i     (req_i),
		.op_i      (op_i),
		.addr_i    (addr_i),
		.wdata_i   (wdata_i),
		.sel_i     (sel_i),
		.ack_o     (ack_o),
		.rdata_o   (rdata_o),
		.sys_rst_o (sys_rst_o),
		.pwr_off_o (pwr_off_o)
	);

	always #4 clk24mhz = ~clk24mhz;

	task automatic compare_word(input logic [31:0] got, input logic [31:0] expected,
			input string what);
		assert (got == expected) else begin
			$display("MISMATCH at %0t ns: %s is %h, expected %h", $time, what, got, expected);
			check_fails++;
		end
	endtask

	task automatic verify_flag(input logic got, input logic expected, input string what);
		assert (got == expected) else begin
			$display("MISMATCH at %0t ns: %s is %b, expected %b", $time, what, got, expected);
			check_fails++;
		end
	endtask

	// Two words per slave in map order: id with useintr in bit 31, then map size
	function automatic logic [31:0] table_word(input logic [31:0] addr);
		logic [31:0] idx;
		logic [31:0] word;
		idx = (addr - `DEVTBL_BASE) >> 2;
		case (idx)
			32'd0:   word = {`SCRATCH_USEINTR, 15'd0, `SCRATCH_ID};
			32'd1:   word = `SCRATCH_MAPSZ;
			32'd2:   word = {`DEVTBL_USEINTR, 15'd0, `DEVTBL_ID};
			32'd3:   word = `DEVTBL_MAPSZ;
			default: word = 32'd0;
		endcase
		return word;
	endfunction

	task automatic load_patterns(output int count);
		int               fd;
		int               code;
		logic [7:0]       tok;
		logic [31:0]      f_op;
		logic [31:0]      f_addr;
		logic [31:0]      f_wdata;
		logic [31:0]      f_sel;
		logic [31:0]      f_exp;
		logic [8*128-1:0] skipped;
		count = 0;
		fd = $fopen("testbench/soc_patterns.txt", "r");
		if (fd == 0) begin
			$display("ERROR: cannot open testbench/soc_patterns.txt");
			return;
		end
		code = $fscanf(fd, "%s", tok);
		while (code == 1) begin
			if (tok == "#") begin
				code = $fgets(skipped, fd);
			end else begin
				code = $fscanf(fd, "%h %h %h %h %h", f_op, f_addr, f_wdata, f_sel, f_exp);
				if (code != 5) begin
					$display("ERROR: pattern %0d in the pattern file is malformed", count + 1);
					count = 0;
					break;
				end
				pat_cmd.push_back(tok);
				pat_op.push_back(f_op[1:0]);
				pat_addr.push_back(f_addr);
				pat_wdata.push_back(f_wdata);
				pat_sel.push_back(f_sel[3:0]);
				pat_exp.push_back(f_exp);
				count++;
			end
			code = $fscanf(fd, "%s", tok);
		end
		$fclose(fd);
	endtask

	// Board reset with a request held up, which the DUT must not answer
	task automatic pulse_board_reset();
		@(negedge clk24mhz);
		rst_p  = 1'b1;
		op_i   = OP_RD;
		addr_i = '0;
		req_i  = 1'b1;
		repeat (10) begin
			@(negedge clk24mhz);
			verify_flag(ack_o, 1'b0, "ack_o during rst_p");
		end
		rst_p = 1'b0;
		// Dropped well before the counter runs out
		repeat (4) begin
			@(negedge clk24mhz);
			verify_flag(ack_o, 1'b0, "ack_o during counted reset");
		end
		req_i = 1'b0;
	endtask

	// Starts and ends on a falling edge
	task automatic run_access(input logic [1:0] op, input logic [31:0] addr,
			input logic [31:0] wdata, input logic [3:0] sel, input logic [31:0] expected);
		int          waited;
		logic [31:0] got;
		op_i    = pi1_op_t'(op);
		addr_i  = addr;
		wdata_i = wdata;
		sel_i   = sel;
		req_i   = 1'b1;
		waited  = 0;
		do begin
			@(negedge clk24mhz);
			waited++;
		end while (!ack_o);
		got = rdata_o;
		compare_word(got, expected, "rdata_o");
		// Ack comes on the third edge after the one that samples req_i
		compare_word(32'(waited), 32'd4, "falling edges from req_i to ack_o");
		if (pi1_op_t'(op) == OP_RD && addr >= `DEVTBL_BASE
				&& addr < (`DEVTBL_BASE + `DEVTBL_MAPSZ) && addr[7:2] != `CTRL_WORD)
			compare_word(got, table_word(addr), "device table word against soc_cfg");
		req_i = 1'b0;
		while (ack_o)
			@(negedge clk24mhz);
	endtask

	task automatic await_reset_release(input logic expected);
		verify_flag(sys_rst_o, 1'b1, "sys_rst_o before release");
		while (sys_rst_o)
			@(negedge clk24mhz);
		verify_flag(pwr_off_o, expected, "pwr_off_o after release");
	endtask

	task automatic hold_power_off(input logic expected);
		verify_flag(pwr_off_o, expected, "pwr_off_o after power-off request");
		repeat (40) begin
			@(negedge clk24mhz);
			verify_flag(sys_rst_o, 1'b1, "sys_rst_o during power-off");
		end
		pulse_board_reset();
	endtask

	task automatic idle_gap();
		repeat ($urandom % 4)
			@(negedge clk24mhz);
	endtask

	initial begin : run_tests
		int          n_loaded;
		int          t;
		int          mark;
		int          passed;
		int          failed;
		string       verdict;
		rst_p     = 1'b1;
		req_i     = 1'b0;
		op_i      = OP_NOP;
		addr_i    = '0;
		wdata_i   = '0;
		sel_i     = '0;
		void'($urandom(32'hef2113f0));
		load_patterns(n_loaded);
		watchdog_cycles = n_loaded * 60 + 500;
		patterns_loaded = 1'b1;
		mark   = 0;
		passed = 0;
		failed = 0;
		if (n_loaded == 0) begin
			$display("ERROR: no usable patterns, nothing was tested");
			$display("Regression failed");
		end else begin
			pulse_board_reset();
			for (t = 0; t < n_loaded; t++) begin
				case (pat_cmd[t])
					"A": begin
						run_access(pat_op[t], pat_addr[t], pat_wdata[t], pat_sel[t],
							pat_exp[t]);
						idle_gap();
					end
					"W": await_reset_release(pat_exp[t][0]);
					"P": hold_power_off(pat_exp[t][0]);
					default: begin
						$display("ERROR: unknown command %c in pattern %0d", pat_cmd[t], t + 1);
						check_fails++;
					end
				endcase
				if (check_fails == mark) begin
					passed++;
					verdict = "ok";
				end else begin
					failed++;
					verdict = "FAILED";
				end
				$display("test %2d %c op %0d addr %h: %s", t + 1, pat_cmd[t], pat_op[t],
					pat_addr[t], verdict);
				mark = check_fails;
			end
			$display("Summary: %0d tests, %0d passed, %0d failed", n_loaded, passed, failed);
			if (failed == 0)
				$display("Regression passed");
			else
				$display("Regression failed");
		end
		$finish;
	end

	initial begin : watchdog_timer
		wait (patterns_loaded);
		repeat (watchdog_cycles)
			@(posedge clk24mhz);
		$display("ERROR: no progress within %0d cycles, an access or a reset wait hung",
			watchdog_cycles);
		$display("Regression failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+hw
hw/soc_pkg.sv
hw/pi1_stage_if.sv
hw/rst_seq.sv
hw/dev_table.sv
hw/dev_stage.sv
hw/addr_decode.sv
hw/soc_top.sv
testbench/tb_soc.sv

// ==== Makefile ====
# Verilator build and run of the bus core testbench

TOP := tb_soc

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -f all.f

# The status comes from grep, so a failing run fails the target
run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -qx "Regression passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== testbench/soc_patterns.txt ====
# cmd op addr wdata sel expect; all but cmd in hex; op 0 nop, 1 wr, 2 rd, 3 swap
# A access checks rdata_o, W waits for reset release, P holds power-off then pulses rst_p
W 0 00000000 00000000 0 00000000
A 1 00000000 11223344 f 00000000
A 2 00000000 00000000 f 11223344
A 1 00000000 aabbccdd 5 00000000
A 2 00000000 00000000 f 11bb33dd
A 1 00000008 01020304 f 00000000
A 3 00000008 ffffffff c 01020304
A 2 00000008 00000000 f ffff0304
A 3 00000000 cafef00d f 11bb33dd
A 2 00000000 00000000 f cafef00d
A 1 000003fc deadbeef f 00000000
A 1 000003fd 00005500 2 00000000
A 2 000003fc 00000000 f dead55ef
A 0 00000004 12345678 f 00000000
A 2 00000400 00000000 f 00000001
A 2 00000404 00000000 f 00000400
A 2 00000408 00000000 f 00000007
A 2 0000040c 00000000 f 00000100
A 2 00000410 00000000 f 00000000
A 2 00000414 00000000 f 00000000
A 1 00000404 ffffffff f 00000000
A 2 00000404 00000000 f 00000400
A 2 000004fc 00000000 f 00000000
A 1 00000500 55555555 f 00000000
A 2 00000500 00000000 f 00000000
A 3 fffffffc 12345678 f 00000000
A 2 00001000 00000000 f 00000000
A 1 000004fc 00000002 f 00000000
W 0 00000000 00000000 0 00000000
A 2 000004fc 00000000 f 00000000
A 2 00000000 00000000 f cafef00d
A 2 000003fc 00000000 f dead55ef
A 1 000004fc 00000001 f 00000000
P 0 00000000 00000000 0 00000001
W 0 00000000 00000000 0 00000000
A 2 00000008 00000000 f ffff0304
